// ==== src/mem_bus_pkg.sv ====
// memory bus definitions
// widths of the shared 64-bit bus and the word layout seen by each requester

package mem_bus_pkg;

    ////////////////////////////////////////////////////////////
    // bus geometry

    localparam int unsigned ADDR_W     = 32;  // byte address
    localparam int unsigned MEM_W      = 64;  // full bus word
    localparam int unsigned LANE_W     = 32;  // scalar and fetch lane
    localparam int unsigned NUM_LANES  = MEM_W / LANE_W;
    localparam int unsigned LANE_IDX_W = 1;   // log2 of NUM_LANES
    localparam int unsigned BE_W       = MEM_W / 8;

    ////////////////////////////////////////////////////////////
    // memory word

    // the vector port and the bus see one whole word, while the scalar
    // and fetch ports pick a single 32-bit lane out of it
    typedef union packed {
        logic [MEM_W-1:0]                 word;
        logic [NUM_LANES-1:0][LANE_W-1:0] lane;  // lane 0 at the low bytes
    } mem_word_t;

endpackage

// ==== src/req_track_pkg.sv ====
// request tracking definitions
// source encoding of granted requests and size of the outstanding queue

package req_track_pkg;

    // requester that owns a granted bus transfer
    typedef enum logic [1:0] {
        SRC_INSTR = 2'd0,
        SRC_SDATA = 2'd1,
        SRC_VDATA = 2'd2
    } src_e;

    localparam int unsigned TRACK_DEPTH = 8;  // outstanding grants
    localparam int unsigned TRACK_CNT_W = 4;  // holds 0 to TRACK_DEPTH

endpackage

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps
// memory request interface
// req/gnt handshake carrying one bus request, transfer when both are high

interface mem_req_if;

    logic                           req;
    logic [mem_bus_pkg::ADDR_W-1:0] addr;
    logic                           we;
    logic [mem_bus_pkg::BE_W-1:0]   be;
    mem_bus_pkg::mem_word_t         wdata;
    logic                           gnt;

    // requester side, holds req until gnt
    modport master (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt
    );

    // arbiter side
    modport slave (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt
    );

endinterface

// ==== src/data_arbiter.sv ====
`timescale 1ns/1ps
// data arbiter
// merges scalar and vector data requests, vector first, and steers scalar lanes

module data_arbiter (
    input  logic                               sdata_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]     sdata_addr_i,
    input  logic                               sdata_we_i,
    input  logic [mem_bus_pkg::LANE_W/8-1:0]   sdata_be_i,
    input  logic [mem_bus_pkg::LANE_W-1:0]     sdata_wdata_i,
    output logic                               sdata_gnt_o,

    input  logic                               vdata_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]     vdata_addr_i,
    input  logic                               vdata_we_i,
    input  logic [mem_bus_pkg::BE_W-1:0]       vdata_be_i,
    input  mem_bus_pkg::mem_word_t             vdata_wdata_i,
    output logic                               vdata_gnt_o,

    input  logic                               vec_pending_load_i,
    input  logic                               vec_pending_store_i,

    mem_req_if.master                          data_o
);

    logic                                 sdata_hold;
    logic [mem_bus_pkg::LANE_IDX_W-1:0]   sdata_lane;
    logic [mem_bus_pkg::BE_W-1:0]         sdata_be;
    mem_bus_pkg::mem_word_t               sdata_word;

    ////////////////////////////////////////////////////////////
    // hold rules

    // a pending vector store blocks all scalar accesses, a pending
    // vector load only blocks scalar writes
    assign sdata_hold = vdata_req_i
                      | vec_pending_store_i
                      | (vec_pending_load_i & sdata_we_i);

    ////////////////////////////////////////////////////////////
    // scalar lane steering

    assign sdata_lane = sdata_addr_i[$clog2(mem_bus_pkg::LANE_W / 8) +: mem_bus_pkg::LANE_IDX_W];

    always_comb begin
        sdata_be = '0;
        sdata_be[sdata_lane * (mem_bus_pkg::LANE_W / 8) +: mem_bus_pkg::LANE_W / 8] = sdata_be_i;
        for (int i = 0; i < mem_bus_pkg::NUM_LANES; i++) begin
            sdata_word.lane[i] = sdata_wdata_i;  // byte enables pick the lane
        end
    end

    ////////////////////////////////////////////////////////////
    // merged request

    always_comb begin
        data_o.req = vdata_req_i | (sdata_req_i & ~sdata_hold);
        if (vdata_req_i) begin
            data_o.addr  = vdata_addr_i;
            data_o.we    = vdata_we_i;
            data_o.be    = vdata_be_i;
            data_o.wdata = vdata_wdata_i;
        end else begin
            data_o.addr  = sdata_addr_i;
            data_o.we    = sdata_we_i;
            data_o.be    = sdata_be;
            data_o.wdata = sdata_word;
        end
    end

    assign sdata_gnt_o = data_o.gnt & sdata_req_i & ~sdata_hold;
    assign vdata_gnt_o = data_o.gnt & vdata_req_i;

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/1ps
// bus arbiter
// data before instruction fetch, drives the memory bus and reports each grant

module bus_arbiter (
    mem_req_if.slave                            data_i,
    mem_req_if.slave                            instr_i,
    input  logic                                grant_vec_i,  // data grant went to vector
    input  logic                                track_full_i,

    output logic                                mem_req_o,
    output logic [mem_bus_pkg::ADDR_W-1:0]      mem_addr_o,
    output logic                                mem_we_o,
    output logic [mem_bus_pkg::BE_W-1:0]        mem_be_o,
    output logic [mem_bus_pkg::MEM_W-1:0]       mem_wdata_o,

    output logic                                grant_o,
    output req_track_pkg::src_e                 grant_src_o,
    output logic                                grant_we_o,
    output logic [mem_bus_pkg::LANE_IDX_W-1:0]  grant_lane_o
);

    logic data_go;
    logic instr_go;

    // nothing leaves while the tracker cannot take another entry
    assign data_go  = data_i.req & ~track_full_i;
    assign instr_go = instr_i.req & ~data_i.req & ~track_full_i;

    assign data_i.gnt  = data_go;
    assign instr_i.gnt = instr_go;

    ////////////////////////////////////////////////////////////
    // bus fields

    always_comb begin
        mem_req_o = data_go | instr_go;
        if (data_i.req) begin
            mem_addr_o  = data_i.addr;
            mem_we_o    = data_i.we;
            mem_be_o    = data_i.be;
            mem_wdata_o = data_i.wdata.word;
        end else begin
            mem_addr_o  = instr_i.addr;
            mem_we_o    = 1'b0;               // fetch is always a read
            mem_be_o    = instr_i.be;
            mem_wdata_o = instr_i.wdata.word;
        end
    end

    ////////////////////////////////////////////////////////////
    // grant report to the tracker

    assign grant_o      = mem_req_o;
    assign grant_src_o  = instr_go    ? req_track_pkg::SRC_INSTR :
                          grant_vec_i ? req_track_pkg::SRC_VDATA : req_track_pkg::SRC_SDATA;
    assign grant_we_o   = mem_we_o;
    assign grant_lane_o = mem_addr_o[$clog2(mem_bus_pkg::LANE_W / 8) +: mem_bus_pkg::LANE_IDX_W];

endmodule

// ==== src/resp_router.sv ====
`timescale 1ns/1ps
// response router
// in-order queue of granted requests, steers each memory response to its owner

module resp_router (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    input  logic                                grant_i,
    input  req_track_pkg::src_e                 grant_src_i,
    input  logic                                grant_we_i,
    input  logic [mem_bus_pkg::LANE_IDX_W-1:0]  grant_lane_i,
    output logic                                track_full_o,

    input  logic                                mem_rvalid_i,
    input  logic                                mem_err_i,
    input  mem_bus_pkg::mem_word_t              mem_rdata_i,

    output logic                                instr_rvalid_o,
    output logic [mem_bus_pkg::LANE_W-1:0]      instr_rdata_o,
    output logic                                instr_err_o,

    output logic                                sdata_rvalid_o,
    output logic [mem_bus_pkg::LANE_W-1:0]      sdata_rdata_o,
    output logic                                sdata_err_o,

    output logic                                vdata_rvalid_o,
    output mem_bus_pkg::mem_word_t              vdata_rdata_o,
    output logic                                vdata_err_o
);

    localparam int unsigned DEPTH = req_track_pkg::TRACK_DEPTH;

    req_track_pkg::src_e                src_q  [DEPTH];
    req_track_pkg::src_e                src_d  [DEPTH];
    logic                               we_q   [DEPTH];  // marks write acks
    logic                               we_d   [DEPTH];
    logic [mem_bus_pkg::LANE_IDX_W-1:0] lane_q [DEPTH];
    logic [mem_bus_pkg::LANE_IDX_W-1:0] lane_d [DEPTH];
    logic [req_track_pkg::TRACK_CNT_W-1:0] cnt_q, cnt_d;
    logic [req_track_pkg::TRACK_CNT_W-1:0] wr_idx;
    logic [req_track_pkg::TRACK_CNT_W-2:0] wr_slot;
    logic                               pop;
    logic                               head_we;

    ////////////////////////////////////////////////////////////
    // shift queue

    assign pop          = mem_rvalid_i & (cnt_q != '0);
    assign track_full_o = (cnt_q == req_track_pkg::TRACK_CNT_W'(DEPTH));
    assign wr_idx       = pop ? cnt_q - 1'b1 : cnt_q;  // slot behind the shifted entries
    assign wr_slot      = wr_idx[req_track_pkg::TRACK_CNT_W-2:0];

    always_comb begin
        src_d  = src_q;
        we_d   = we_q;
        lane_d = lane_q;
        if (pop) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                src_d[i]  = src_q[i+1];
                we_d[i]   = we_q[i+1];
                lane_d[i] = lane_q[i+1];
            end
        end
        if (grant_i) begin
            src_d[wr_slot]  = grant_src_i;
            we_d[wr_slot]   = grant_we_i;
            lane_d[wr_slot] = grant_lane_i;
        end
        cnt_d = cnt_q + {{(req_track_pkg::TRACK_CNT_W-1){1'b0}}, grant_i}
                      - {{(req_track_pkg::TRACK_CNT_W-1){1'b0}}, pop};
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        src_q  <= src_d;
        we_q   <= we_d;
        lane_q <= lane_d;
    end

    ////////////////////////////////////////////////////////////
    // response steering

    assign head_we = we_q[0];

    assign instr_rvalid_o = pop & (src_q[0] == req_track_pkg::SRC_INSTR);
    assign sdata_rvalid_o = pop & (src_q[0] == req_track_pkg::SRC_SDATA);
    assign vdata_rvalid_o = pop & (src_q[0] == req_track_pkg::SRC_VDATA);

    // write acks carry no meaningful data
    assign instr_rdata_o  = mem_rdata_i.lane[lane_q[0]];
    assign sdata_rdata_o  = head_we ? '0 : mem_rdata_i.lane[lane_q[0]];
    assign vdata_rdata_o  = mem_rdata_i;

    assign instr_err_o    = instr_rvalid_o & mem_err_i;
    assign sdata_err_o    = sdata_rvalid_o & mem_err_i;
    assign vdata_err_o    = vdata_rvalid_o & mem_err_i;

endmodule

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/1ps
// memory subsystem top
// fetch, scalar and vector ports sharing one 64-bit memory bus

module mem_subsys_top (
    input  logic                                clk_i,
    input  logic                                rst_ni,

    // instruction fetch
    input  logic                                instr_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]      instr_addr_i,
    output logic                                instr_gnt_o,
    output logic                                instr_rvalid_o,
    output logic [mem_bus_pkg::LANE_W-1:0]      instr_rdata_o,
    output logic                                instr_err_o,

    // scalar data
    input  logic                                sdata_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]      sdata_addr_i,
    input  logic                                sdata_we_i,
    input  logic [mem_bus_pkg::LANE_W/8-1:0]    sdata_be_i,
    input  logic [mem_bus_pkg::LANE_W-1:0]      sdata_wdata_i,
    output logic                                sdata_gnt_o,
    output logic                                sdata_rvalid_o,
    output logic [mem_bus_pkg::LANE_W-1:0]      sdata_rdata_o,
    output logic                                sdata_err_o,

    // vector data
    input  logic                                vdata_req_i,
    input  logic [mem_bus_pkg::ADDR_W-1:0]      vdata_addr_i,
    input  logic                                vdata_we_i,
    input  logic [mem_bus_pkg::BE_W-1:0]        vdata_be_i,
    input  logic [mem_bus_pkg::MEM_W-1:0]       vdata_wdata_i,
    output logic                                vdata_gnt_o,
    output logic                                vdata_rvalid_o,
    output logic [mem_bus_pkg::MEM_W-1:0]       vdata_rdata_o,
    output logic                                vdata_err_o,

    input  logic                                vec_pending_load_i,
    input  logic                                vec_pending_store_i,

    // memory bus
    output logic                                mem_req_o,
    output logic [mem_bus_pkg::ADDR_W-1:0]      mem_addr_o,
    output logic                                mem_we_o,
    output logic [mem_bus_pkg::BE_W-1:0]        mem_be_o,
    output logic [mem_bus_pkg::MEM_W-1:0]       mem_wdata_o,
    input  logic                                mem_rvalid_i,
    input  logic                                mem_err_i,
    input  logic [mem_bus_pkg::MEM_W-1:0]       mem_rdata_i
);

    mem_req_if data_req ();
    mem_req_if instr_req ();

    logic                               grant;
    req_track_pkg::src_e                grant_src;
    logic                               grant_we;
    logic [mem_bus_pkg::LANE_IDX_W-1:0] grant_lane;
    logic                               track_full;

    // fetch is a plain read of the whole word
    assign instr_req.req   = instr_req_i;
    assign instr_req.addr  = instr_addr_i;
    assign instr_req.we    = 1'b0;
    assign instr_req.be    = '1;
    assign instr_req.wdata = '0;
    assign instr_gnt_o     = instr_req.gnt;

    data_arbiter u_data_arbiter (
        .sdata_req_i         ( sdata_req_i         ),
        .sdata_addr_i        ( sdata_addr_i        ),
        .sdata_we_i          ( sdata_we_i          ),
        .sdata_be_i          ( sdata_be_i          ),
        .sdata_wdata_i       ( sdata_wdata_i       ),
        .sdata_gnt_o         ( sdata_gnt_o         ),
        .vdata_req_i         ( vdata_req_i         ),
        .vdata_addr_i        ( vdata_addr_i        ),
        .vdata_we_i          ( vdata_we_i          ),
        .vdata_be_i          ( vdata_be_i          ),
        .vdata_wdata_i       ( vdata_wdata_i       ),
        .vdata_gnt_o         ( vdata_gnt_o         ),
        .vec_pending_load_i  ( vec_pending_load_i  ),
        .vec_pending_store_i ( vec_pending_store_i ),
        .data_o              ( data_req            )
    );

    bus_arbiter u_bus_arbiter (
        .data_i              ( data_req            ),
        .instr_i             ( instr_req           ),
        .grant_vec_i         ( vdata_gnt_o         ),
        .track_full_i        ( track_full          ),
        .mem_req_o           ( mem_req_o           ),
        .mem_addr_o          ( mem_addr_o          ),
        .mem_we_o            ( mem_we_o            ),
        .mem_be_o            ( mem_be_o            ),
        .mem_wdata_o         ( mem_wdata_o         ),
        .grant_o             ( grant               ),
        .grant_src_o         ( grant_src           ),
        .grant_we_o          ( grant_we            ),
        .grant_lane_o        ( grant_lane          )
    );

    resp_router u_resp_router (
        .clk_i               ( clk_i               ),
        .rst_ni              ( rst_ni              ),
        .grant_i             ( grant               ),
        .grant_src_i         ( grant_src           ),
        .grant_we_i          ( grant_we            ),
        .grant_lane_i        ( grant_lane          ),
        .track_full_o        ( track_full          ),
        .mem_rvalid_i        ( mem_rvalid_i        ),
        .mem_err_i           ( mem_err_i           ),
        .mem_rdata_i         ( mem_rdata_i         ),
        .instr_rvalid_o      ( instr_rvalid_o      ),
        .instr_rdata_o       ( instr_rdata_o       ),
        .instr_err_o         ( instr_err_o         ),
        .sdata_rvalid_o      ( sdata_rvalid_o      ),
        .sdata_rdata_o       ( sdata_rdata_o       ),
        .sdata_err_o         ( sdata_err_o         ),
        .vdata_rvalid_o      ( vdata_rvalid_o      ),
        .vdata_rdata_o       ( vdata_rdata_o       ),
        .vdata_err_o         ( vdata_err_o         )
    );

endmodule

// ==== tb/mem_subsys_asserts.sv ====
`timescale 1ns/1ps
// protocol checks on the memory subsystem top level

module mem_subsys_asserts (
    input logic clk_i,
    input logic rst_ni,
    input logic instr_gnt_o,
    input logic sdata_gnt_o,
    input logic vdata_gnt_o,
    input logic instr_rvalid_o,
    input logic sdata_rvalid_o,
    input logic vdata_rvalid_o,
    input logic vdata_req_i
);

    // one response owner per cycle
    one_rvalid: assert property (@(posedge clk_i)
        $onehot0({instr_rvalid_o, sdata_rvalid_o, vdata_rvalid_o}))
        else $error("more than one rvalid output high");

    no_grant_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !(instr_gnt_o || sdata_gnt_o || vdata_gnt_o))
        else $error("grant high during reset");

    vector_first: assert property (@(posedge clk_i) disable iff (!rst_ni)
        sdata_gnt_o |-> !vdata_req_i)
        else $error("scalar granted while vector requests");

endmodule

bind mem_subsys_top mem_subsys_asserts u_asserts (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_gnt_o    ( instr_gnt_o    ),
    .sdata_gnt_o    ( sdata_gnt_o    ),
    .vdata_gnt_o    ( vdata_gnt_o    ),
    .instr_rvalid_o ( instr_rvalid_o ),
    .sdata_rvalid_o ( sdata_rvalid_o ),
    .vdata_rvalid_o ( vdata_rvalid_o ),
    .vdata_req_i    ( vdata_req_i    )
);

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ps
// testbench for the memory subsystem
// memory model with random latency, per-requester expected queues, directed tests

module tb_mem_subsys;

    logic        clk_i = 1'b0, rst_ni = 1'b0;
    logic        instr_req_i = 1'b0, sdata_req_i = 1'b0, sdata_we_i = 1'b0;
    logic        vdata_req_i = 1'b0, vdata_we_i = 1'b0;
    logic        vec_pending_load_i = 1'b0, vec_pending_store_i = 1'b0;
    logic [31:0] instr_addr_i = '0, sdata_addr_i = '0, sdata_wdata_i = '0, vdata_addr_i = '0;
    logic [3:0]  sdata_be_i = '0;
    logic [7:0]  vdata_be_i = '0;
    logic [63:0] vdata_wdata_i = '0, mem_rdata_i = '0;
    logic        mem_rvalid_i = 1'b0, mem_err_i = 1'b0;
    logic        instr_gnt_o, instr_rvalid_o, instr_err_o, sdata_gnt_o, sdata_rvalid_o;
    logic        sdata_err_o, vdata_gnt_o, vdata_rvalid_o, vdata_err_o, mem_req_o, mem_we_o;
    logic [31:0] instr_rdata_o, sdata_rdata_o, mem_addr_o;
    logic [63:0] vdata_rdata_o, mem_wdata_o;
    logic [7:0]  mem_be_o;

    logic [7:0]  mem_bytes [int unsigned];  // memory model
    logic [7:0]  shadow [int unsigned];     // expected contents
    logic [63:0] resp_q [$];
    int          delay_q [$];
    logic        err_q [$];                 // error flag of each queued response
    logic [31:0] exp_instr [$];
    logic [32:0] exp_sdata [$];             // bit 32 marks a write ack
    logic [63:0] exp_vdata [$];
    logic [31:0] rng_state = 32'd67;
    int          errors = 0;

    mem_subsys_top dut_i (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [7:0] fill_byte(logic [31:0] a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
    endfunction

    function automatic logic [7:0] shadow_byte(logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : fill_byte(a);
    endfunction

    task automatic report_failure(string msg);
        errors++;
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else
            report_failure($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // memory model: accept at posedge, answer in order on negedge
    always @(posedge clk_i) begin
        logic [31:0] base;
        logic [63:0] rd;
        logic [31:0] r;
        if (mem_req_o) begin
            base = {mem_addr_o[31:3], 3'b0};
            for (int i = 0; i < 8; i++) begin
                if (mem_we_o && mem_be_o[i]) mem_bytes[base + i] = mem_wdata_o[8*i +: 8];
                rd[8*i +: 8] = mem_bytes.exists(base + i) ? mem_bytes[base + i]
                                                          : fill_byte(base + i);
            end
            r = next_rand();
            resp_q.push_back(rd);
            delay_q.push_back(int'(r % 4) + 1);
            err_q.push_back(r[10:8] == 3'b0);  // about one response in eight fails
        end
    end

    always @(negedge clk_i) begin
        mem_rvalid_i = 1'b0;
        mem_err_i    = 1'b0;
        if (resp_q.size() > 0) begin
            if (delay_q[0] > 1) delay_q[0]--;
            else begin
                mem_rvalid_i = 1'b1;
                mem_err_i    = err_q.pop_front();
                mem_rdata_i  = resp_q.pop_front();
                void'(delay_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // requester monitors: expected values from the shadow memory
    always @(posedge clk_i) begin
        logic [31:0] a;
        logic [32:0] s;
        logic [63:0] v;
        assert (!(instr_err_o && !instr_rvalid_o) && !(sdata_err_o && !sdata_rvalid_o) &&
                !(vdata_err_o && !vdata_rvalid_o)) else
            report_failure("an error flag was raised without a response");
        if (instr_rvalid_o) begin
            assert (exp_instr.size() > 0) else report_failure("unexpected fetch response");
            check_value("instr_rdata_o", instr_rdata_o, exp_instr.pop_front());
            check_value("instr_err_o", instr_err_o, mem_err_i);
        end
        if (sdata_rvalid_o) begin
            assert (exp_sdata.size() > 0) else report_failure("unexpected scalar response");
            s = exp_sdata.pop_front();
            // write acks carry no scalar data
            check_value("sdata_rdata_o", sdata_rdata_o, s[32] ? 32'h0 : s[31:0]);
            check_value("sdata_err_o", sdata_err_o, mem_err_i);
        end
        if (vdata_rvalid_o) begin
            assert (exp_vdata.size() > 0) else report_failure("unexpected vector response");
            check_value("vdata_rdata_o", vdata_rdata_o, exp_vdata.pop_front());
            check_value("vdata_err_o", vdata_err_o, mem_err_i);
        end
        if (instr_gnt_o) begin
            a = {instr_addr_i[31:2], 2'b0};
            for (int i = 0; i < 4; i++) s[8*i +: 8] = shadow_byte(a + i);
            exp_instr.push_back(s[31:0]);
        end
        if (sdata_gnt_o) begin
            a = {sdata_addr_i[31:2], 2'b0};
            for (int i = 0; i < 4; i++) begin
                if (sdata_we_i && sdata_be_i[i]) shadow[a + i] = sdata_wdata_i[8*i +: 8];
                s[8*i +: 8] = shadow_byte(a + i);
            end
            s[32] = sdata_we_i;
            exp_sdata.push_back(s);
        end
        if (vdata_gnt_o) begin
            a = {vdata_addr_i[31:3], 3'b0};
            for (int i = 0; i < 8; i++) begin
                if (vdata_we_i && vdata_be_i[i]) shadow[a + i] = vdata_wdata_i[8*i +: 8];
                v[8*i +: 8] = shadow_byte(a + i);
            end
            exp_vdata.push_back(v);
        end
    end

    ////////////////////////////////////////////////////////////
    // request helpers
    task automatic wait_grant(ref logic gnt, input string name);
        int n;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            assert (n < 100) else report_failure({"timeout waiting for ", name});
        end while (!gnt);
    endtask

    task automatic scalar_access(logic [31:0] addr, logic we, logic [3:0] be, logic [31:0] wd);
        @(negedge clk_i);
        {sdata_req_i, sdata_addr_i, sdata_we_i, sdata_be_i, sdata_wdata_i} = {1'b1, addr, we, be, wd};
        wait_grant(sdata_gnt_o, "sdata_gnt_o");
        check_value("mem_be_o", mem_be_o, addr[2] ? {be, 4'h0} : {4'h0, be});
        @(negedge clk_i);
        sdata_req_i = 1'b0;
    endtask

    task automatic vector_access(logic [31:0] addr, logic we, logic [7:0] be, logic [63:0] wd);
        @(negedge clk_i);
        {vdata_req_i, vdata_addr_i, vdata_we_i, vdata_be_i, vdata_wdata_i} = {1'b1, addr, we, be, wd};
        wait_grant(vdata_gnt_o, "vdata_gnt_o");
        @(negedge clk_i);
        vdata_req_i = 1'b0;
    endtask

    task automatic fetch(logic [31:0] addr);
        @(negedge clk_i);
        {instr_req_i, instr_addr_i} = {1'b1, addr};
        wait_grant(instr_gnt_o, "instr_gnt_o");
        @(negedge clk_i);
        instr_req_i = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (resp_q.size() + exp_instr.size() + exp_sdata.size() + exp_vdata.size() > 0) begin
            @(posedge clk_i);
            n++;
            assert (n < 200) else report_failure("responses did not drain from the memory");
        end
    endtask

    task automatic check_held(ref logic gnt, input string name);
        repeat (5) begin
            @(posedge clk_i);
            assert (!gnt) else report_failure({name, " was granted while held"});
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic test_reset();
        repeat (16) begin
            @(posedge clk_i);
            check_value("grants", {instr_gnt_o, sdata_gnt_o, vdata_gnt_o, mem_req_o}, '0);
            check_value("rvalids", {instr_rvalid_o, sdata_rvalid_o, vdata_rvalid_o}, '0);
        end
        @(negedge clk_i);
        rst_ni = 1'b1;
        repeat (2) @(posedge clk_i);
        check_value("mem_req_o", mem_req_o, 1'b0);
    endtask

    task automatic test_scalar_lanes();
        scalar_access(32'h100, 1'b1, 4'b0011, 32'hcafe_1234);
        scalar_access(32'h104, 1'b1, 4'b1111, 32'h8765_4321);
        scalar_access(32'h100, 1'b0, 4'b1111, '0);
        scalar_access(32'h104, 1'b0, 4'b1111, '0);
        wait_idle();
    endtask

    task automatic test_vector();
        vector_access(32'h200, 1'b1, 8'hff, 64'h0123_4567_89ab_cdef);
        vector_access(32'h208, 1'b1, 8'h3c, 64'hfeed_face_dead_beef);
        vector_access(32'h200, 1'b0, 8'hff, '0);
        vector_access(32'h208, 1'b0, 8'hff, '0);
        wait_idle();
    endtask

    task automatic test_priority();
        @(negedge clk_i);
        {instr_req_i, instr_addr_i} = {1'b1, 32'h204};
        {sdata_req_i, sdata_addr_i, sdata_we_i, sdata_be_i} = {1'b1, 32'h300, 1'b0, 4'hf};
        @(posedge clk_i);
        check_value("sdata_gnt_o", sdata_gnt_o, 1'b1);
        check_value("instr_gnt_o", instr_gnt_o, 1'b0);
        @(negedge clk_i);
        sdata_req_i = 1'b0;
        wait_grant(instr_gnt_o, "instr_gnt_o");
        @(negedge clk_i);
        instr_req_i = 1'b0;
        wait_idle();
    endtask

    task automatic test_hold_rules();
        @(negedge clk_i);
        vec_pending_store_i = 1'b1;
        {sdata_req_i, sdata_addr_i, sdata_we_i, sdata_be_i} = {1'b1, 32'h104, 1'b0, 4'hf};
        check_held(sdata_gnt_o, "scalar read under pending store");
        @(negedge clk_i);
        vec_pending_store_i = 1'b0;
        wait_grant(sdata_gnt_o, "sdata_gnt_o");
        @(negedge clk_i);
        sdata_req_i = 1'b0;
        vec_pending_load_i = 1'b1;
        scalar_access(32'h100, 1'b0, 4'hf, '0);
        @(negedge clk_i);
        {sdata_req_i, sdata_addr_i, sdata_we_i, sdata_wdata_i} = {1'b1, 32'h108, 1'b1, 32'h5555_aaaa};
        check_held(sdata_gnt_o, "scalar write under pending load");
        @(negedge clk_i);
        vec_pending_load_i = 1'b0;
        wait_grant(sdata_gnt_o, "sdata_gnt_o");
        @(negedge clk_i);
        sdata_req_i = 1'b0;
        wait_idle();
    endtask

    task automatic test_mixed();
        logic [31:0] r;
        logic [31:0] a;
        for (int k = 0; k < 60; k++) begin
            r = next_rand();
            a = 32'h400 + (r[11:4] & 8'hfc);
            case (r % 3)
                0: fetch(a);
                1: scalar_access(a, r[12], r[16:13], next_rand());
                default: vector_access(a, r[12], r[23:16], {next_rand(), next_rand()});
            endcase
        end
        wait_idle();
    endtask

    initial begin
        test_reset();
        test_scalar_lanes();
        test_vector();
        test_priority();
        test_hold_rules();
        test_mixed();
        if (errors == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1);
        end
    end

    // overall limit on the run
    initial begin
        #2ms;
        $display("simulation timed out");
        $display("Verification failed");
        $fatal(1);
    end

endmodule

// ==== mem_subsys_top.f ====
src/mem_bus_pkg.sv
src/req_track_pkg.sv
src/mem_req_if.sv
src/data_arbiter.sv
src/bus_arbiter.sv
src/resp_router.sv
src/mem_subsys_top.sv
tb/mem_subsys_asserts.sv
tb/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_mem_subsys
FILELIST  := mem_subsys_top.f
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
